/* Bender.yml */
package:
  name: keccak_absorb

sources:
  - verilog/keccak_absorb_pkg.sv
  - verilog/msg_loader.sv
  - verilog/word_fifo.sv
  - verilog/block_padder.sv
  - verilog/keccak_absorb_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_keccak_absorb.sv

/* dv/absorb_ref_model.svh */
`ifndef ABSORB_REF_MODEL_SVH
`define ABSORB_REF_MODEL_SVH

// expected lane plus a flag for the last lane of a padded message
typedef struct packed {
    logic  fin;
    lane_t lane;
} exp_lane_t;

logic [7:0] byte_q [$];
exp_lane_t  exp_q [$];
int         model_mode;
// position inside the current rate block
int         blk_bytes;
int         blk_lanes;

// rate in bytes per mode encoding
function automatic int mode_rate(input int m);
    case (m)
        0: return 136;
        1: return 72;
        2: return 168;
        3: return 136;
        4: return 144;
        default: return 104;
    endcase
endfunction

function automatic logic [7:0] model_domain(input int m);
    return (m == 2 || m == 3) ? 8'h1F : 8'h06;
endfunction

// lanes still queued belong to the discarded message
function automatic void model_init(input int m);
    model_mode = m;
    blk_bytes  = 0;
    blk_lanes  = 0;
    byte_q.delete();
    exp_q.delete();
endfunction

////////////////////
// lane packing
////////////////////
function automatic void emit_lanes(input logic msg_end);
    exp_lane_t   e;
    logic [31:0] w;
    while (byte_q.size() >= 4) begin
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = byte_q.pop_front();
        end
        blk_lanes         = blk_lanes + 1;
        e.lane.data       = w;
        e.lane.block_last = (blk_lanes == mode_rate(model_mode) / 4);
        e.fin             = msg_end && (byte_q.size() == 0);
        if (e.lane.block_last) begin
            blk_lanes = 0;
        end
        exp_q.push_back(e);
    end
endfunction

function automatic void model_push(input logic [7:0] b);
    byte_q.push_back(b);
    blk_bytes = (blk_bytes + 1) % mode_rate(model_mode);
    emit_lanes(1'b0);
endfunction

////////////////////
// pad10*1
////////////////////
function automatic void model_pad();
    int rate;
    rate = mode_rate(model_mode);
    byte_q.push_back(model_domain(model_mode));
    blk_bytes = (blk_bytes + 1) % rate;
    while (blk_bytes != 0) begin
        byte_q.push_back(8'h00);
        blk_bytes = (blk_bytes + 1) % rate;
    end
    byte_q[byte_q.size() - 1] = byte_q[byte_q.size() - 1] | 8'h80;
    emit_lanes(1'b1);
endfunction

`endif

/* dv/tb_keccak_absorb.sv */
module tb_keccak_absorb
    import keccak_absorb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED   = 32'h993f;
    localparam int          T2_LEN = 400;
    localparam int          T5_LEN = 200;
    localparam int          T6_LEN = 50;

    logic              clk;
    logic              rst_init;
    cmd_t              i_cmd;
    logic              i_cmd_valid;
    logic [LANE_W-1:0] i_din;
    logic              i_wen;
    logic              i_lane_ready;
    logic              o_cmd_ready;
    logic              o_din_ready;
    lane_t             o_lane;
    logic              o_lane_valid;
    logic              o_done;

    string       cur_test = "reset";
    int          err_cnt = 0;
    int          err_start = 0;
    int          test_cnt = 0;
    int          lane_cnt = 0;
    int          stall_cnt = 0;
    int          ready_mode = 0;
    int          hold = 0;
    logic        done_due = 1'b0;
    logic [31:0] rng_stim = SEED;
    logic [31:0] rng_ready = ~SEED;

    `include "absorb_ref_model.svh"

    keccak_absorb_top i_keccak_absorb_top (
        .clk          (clk),
        .rst_init     (rst_init),
        .i_cmd        (i_cmd),
        .i_cmd_valid  (i_cmd_valid),
        .i_din        (i_din),
        .i_wen        (i_wen),
        .i_lane_ready (i_lane_ready),
        .o_cmd_ready  (o_cmd_ready),
        .o_din_ready  (o_din_ready),
        .o_lane       (o_lane),
        .o_lane_valid (o_lane_valid),
        .o_done       (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int mode_len(input int m);
        return 20 + 37 * m;
    endfunction

    function automatic int lanes_for(input int len, input int m);
        return (len / mode_rate(m) + 1) * (mode_rate(m) / 4);
    endfunction

    // 20 cycles per lane and 200 per test
    function automatic int run_budget();
        int lanes;
        lanes = lanes_for(5, 0) + lanes_for(T2_LEN, 2) + lanes_for(71, 1);
        lanes = lanes + lanes_for(72, 1) + lanes_for(3 * T5_LEN, 3) + lanes_for(T6_LEN, 4);
        for (int m = 0; m < 6; m++) begin
            lanes = lanes + lanes_for(mode_len(m), m);
        end
        return 20 * lanes + 6 * 200 + 10;
    endfunction

    ////////////////////
    // lane ready driver
    ////////////////////
    always @(negedge clk) begin
        case (ready_mode)
            0: i_lane_ready = 1'b1;
            1: i_lane_ready = 1'b0;
            default: begin
                if (hold == 0) begin
                    rng_ready    = xorshift32(rng_ready);
                    i_lane_ready = ~i_lane_ready;
                    hold         = i_lane_ready ? rng_ready[2:0] : 8 + rng_ready[4:0];
                end else begin
                    hold = hold - 1;
                end
            end
        endcase
    end

    ////////////////////
    // lane monitor
    ////////////////////
    always @(posedge clk) begin
        exp_lane_t e;
        if (!rst_init) begin
            if (o_done !== done_due) begin
                $display("ERR %0s: o_done expected %b, actual %b", cur_test, done_due, o_done);
                err_cnt++;
            end
            done_due = 1'b0;
            if (o_lane_valid && i_lane_ready) begin
                lane_cnt++;
                if (exp_q.size() == 0) begin
                    $display("%0s: lane %h transferred with no lane expected", cur_test, o_lane);
                    err_cnt++;
                end else begin
                    e = exp_q.pop_front();
                    if (o_lane !== e.lane) begin
                        $display("ERR %0s: lane expected %h, actual %h", cur_test, e.lane, o_lane);
                        err_cnt++;
                    end
                    done_due = e.fin;
                end
            end
        end
    end

    initial begin
        int budget;
        budget = run_budget();
        repeat (budget) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles in %0s", budget, cur_test);
        $display("Simulation failed");
        $finish;
    end

    task automatic send_cmd(input cmd_op_e op, input logic [LEN_W-1:0] arg);
        i_cmd.op          = op;
        i_cmd.arg.byte_len = arg;
        i_cmd_valid       = 1'b1;
        do @(posedge clk); while (!o_cmd_ready);
        @(negedge clk);
        i_cmd_valid = 1'b0;
    endtask

    task automatic do_init(input int m);
        model_init(m);
        send_cmd(CMD_INIT, LEN_W'(m));
    endtask

    // bytes past the length are random and must be ignored
    task automatic absorb(input int len);
        int          left;
        int          n;
        logic [31:0] w;
        send_cmd(CMD_ABSORB, LEN_W'(len));
        left = len;
        while (left > 0) begin
            rng_stim = xorshift32(rng_stim);
            w        = rng_stim;
            n        = (left < 4) ? left : 4;
            for (int i = 0; i < n; i++) begin
                model_push(w[8*i +: 8]);
            end
            i_din = w;
            i_wen = 1'b1;
            do begin
                @(posedge clk);
                if (!o_din_ready) stall_cnt++;
            end while (!o_din_ready);
            @(negedge clk);
            left = left - n;
        end
        i_wen = 1'b0;
    endtask

    task automatic pad_and_wait();
        model_pad();
        send_cmd(CMD_PAD, '0);
        do @(negedge clk); while (exp_q.size() != 0 || !o_cmd_ready);
    endtask

    task automatic set_ready(input int m);
        @(posedge clk);
        ready_mode = m;
        @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        $display("test %0s finished with %0d errors", cur_test, err_cnt - err_start);
    endtask

    initial begin
        int left;
        int n;
        rst_init    = 1'b1;
        i_cmd       = '0;
        i_cmd_valid = 1'b0;
        i_din       = '0;
        i_wen       = 1'b0;
        i_lane_ready = 1'b1;
        repeat (10) @(negedge clk);
        rst_init = 1'b0;

        start_test("sha3_256_short");
        do_init(0);
        absorb(5);
        pad_and_wait();
        end_test();

        // random split lengths over several rate blocks
        start_test("shake128_split");
        do_init(2);
        left = T2_LEN;
        while (left > 0) begin
            rng_stim = xorshift32(rng_stim);
            n        = 1 + rng_stim % 60;
            if (n > left) n = left;
            absorb(n);
            left = left - n;
        end
        pad_and_wait();
        end_test();

        start_test("all_modes");
        for (int m = 0; m < 6; m++) begin
            do_init(m);
            absorb(mode_len(m));
            pad_and_wait();
        end
        end_test();

        start_test("sha3_512_edges");
        do_init(1);
        absorb(71);
        pad_and_wait();
        absorb(72);
        pad_and_wait();
        end_test();

        start_test("backpressure");
        do_init(3);
        stall_cnt = 0;
        set_ready(2);
        repeat (3) absorb(T5_LEN);
        pad_and_wait();
        set_ready(0);
        if (stall_cnt == 0) begin
            $display("%0s: o_din_ready never dropped while lanes were stalled", cur_test);
            err_cnt++;
        end
        end_test();

        // lanes stay blocked so the unpadded bytes never leave
        start_test("mid_init");
        do_init(5);
        set_ready(1);
        absorb(11);
        do_init(4);
        set_ready(0);
        absorb(T6_LEN);
        pad_and_wait();
        end_test();

        repeat (4) @(negedge clk);
        $display("tests %0d, lanes %0d, errors %0d", test_cnt, lane_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* keccak_absorb.f */
+incdir+dv
verilog/keccak_absorb_pkg.sv
verilog/msg_loader.sv
verilog/word_fifo.sv
verilog/block_padder.sv
verilog/keccak_absorb_top.sv
dv/tb_keccak_absorb.sv

/* verilog/block_padder.sv */
module block_padder
    import keccak_absorb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_init,
    input  logic        clear,
    input  hash_mode_e  mode,
    input  fifo_entry_t head,
    input  logic        head_valid,
    input  logic        i_lane_ready,
    output logic        pop,
    output lane_t       o_lane,
    output logic        o_lane_valid,
    output logic        pad_done,
    output logic        o_done
);

    typedef enum logic [1:0] {ST_ABSORB, ST_PAD, ST_DRAIN} pad_state_e;

    pad_state_e                          state_q;
    pad_state_e                          state_d;
    // byte 0 of the stream sits in bits 7:0
    logic [55:0]                         align_q;
    logic [2:0]                          fill_q;
    logic [2:0]                          fill_base;
    logic [7:0]                          pos_q;
    logic [8:0]                          pos_sum;
    logic [$clog2(RATE_MAX_LANES)-1:0]   lane_cnt_q;
    logic                                dom_pend_q;
    logic                                done_q;
    logic [7:0]                          rate;
    logic [7:0]                          rem;
    logic                                lane_xfer;
    logic                                room;
    logic                                block_last;
    logic                                pad_step;
    logic                                pad_last;
    logic [2:0]                          app_n;
    logic [1:0]                          last_idx;
    logic [LANE_W-1:0]                   app_data;

    assign rate         = rate_bytes(mode);
    assign o_lane_valid = (fill_q >= 3'd4);
    assign lane_xfer    = o_lane_valid & i_lane_ready;
    assign block_last   = (8'(lane_cnt_q) == (rate >> 2) - 8'd1);
    assign o_lane.data       = align_q[LANE_W-1:0];
    assign o_lane.block_last = block_last;

    // fill left after this cycle's lane leaves
    assign fill_base = lane_xfer ? fill_q - 3'd4 : fill_q;
    assign room      = (fill_base <= 3'd3);
    assign pop       = head_valid & room & (state_q == ST_ABSORB);

    // bytes still missing from the current block
    assign rem      = rate - pos_q;
    assign pad_step = room & (state_q == ST_PAD);
    assign pad_last = (rem <= 8'd4);
    assign last_idx = 2'(rem[2:0] - 3'd1);

    ////////////////////
    // byte source
    ////////////////////
    always_comb begin
        app_n    = 3'd0;
        app_data = '0;
        if (pop && !head.is_pad) begin
            app_n    = (head.nbytes == 2'd0) ? 3'd4 : {1'b0, head.nbytes};
            app_data = head.data;
        end else if (pad_step) begin
            app_n = pad_last ? rem[2:0] : 3'd4;
            if (dom_pend_q) begin
                app_data[7:0] = domain_byte(mode);
            end
            // closing bit of the pad10*1 rule
            if (pad_last) begin
                app_data[8*last_idx +: 8] = app_data[8*last_idx +: 8] | 8'h80;
            end
        end
        // zero the unused tail of a partial word
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (i >= app_n) app_data[8*i +: 8] = 8'h00;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_ABSORB: if (pop && head.is_pad) state_d = ST_PAD;
            ST_PAD:    if (pad_step && pad_last) state_d = ST_DRAIN;
            // exactly one lane is left, the block_last one
            ST_DRAIN:  if (lane_xfer) state_d = ST_ABSORB;
            default:   state_d = ST_ABSORB;
        endcase
    end

    assign pos_sum = {1'b0, pos_q} + 9'(app_n);

    ////////////////////
    // aligner and counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst_init || clear) begin
            state_q    <= ST_ABSORB;
            align_q    <= '0;
            fill_q     <= '0;
            pos_q      <= '0;
            lane_cnt_q <= '0;
            dom_pend_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            align_q <= (lane_xfer ? {32'h0, align_q[55:32]} : align_q) |
                       (56'(app_data) << (8 * fill_base));
            fill_q  <= fill_base + app_n;
            pos_q   <= (pos_sum >= {1'b0, rate}) ? 8'(pos_sum - {1'b0, rate}) : pos_sum[7:0];
            if (lane_xfer) begin
                lane_cnt_q <= block_last ? '0 : lane_cnt_q + 1'b1;
            end
            if (pop && head.is_pad) begin
                dom_pend_q <= 1'b1;
            end else if (pad_step) begin
                dom_pend_q <= 1'b0;
            end
            done_q <= (state_q == ST_DRAIN) && lane_xfer;
        end
    end

    assign pad_done = done_q;
    assign o_done   = done_q;

endmodule

/* verilog/keccak_absorb_pkg.sv */
package keccak_absorb_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int LANE_W         = 32;
    localparam int WORD_BYTES     = 4;
    localparam int STATE_BYTES    = 200;
    localparam int LEN_W          = 11;
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_AW        = 4;
    localparam int CREDIT_W       = 5;
    localparam int RATE_MAX_LANES = 42;

    typedef enum logic [2:0] {
        SHA3_256  = 3'd0,
        SHA3_512  = 3'd1,
        SHAKE_128 = 3'd2,
        SHAKE_256 = 3'd3,
        SHA3_224  = 3'd4,
        SHA3_384  = 3'd5
    } hash_mode_e;

    // rate is the state minus twice the security level
    function automatic logic [7:0] rate_bytes(hash_mode_e m);
        logic [7:0] cap;
        case (m)
            SHA3_224:            cap = 8'd56;
            SHA3_256, SHAKE_256: cap = 8'd64;
            SHA3_384:            cap = 8'd96;
            SHA3_512:            cap = 8'd128;
            default:             cap = 8'd32;
        endcase
        return 8'(STATE_BYTES) - cap;
    endfunction

    // SHA3 suffix 01, SHAKE suffix 1111
    function automatic logic [7:0] domain_byte(hash_mode_e m);
        return (m == SHAKE_128 || m == SHAKE_256) ? 8'h1F : 8'h06;
    endfunction

    ////////////////////
    // command word
    ////////////////////
    typedef enum logic [1:0] {
        CMD_INIT   = 2'd0,
        CMD_ABSORB = 2'd1,
        CMD_PAD    = 2'd2
    } cmd_op_e;

    typedef struct packed {
        logic [LEN_W-4:0] rsvd;
        hash_mode_e       mode;
    } init_arg_t;

    // byte length for absorb, mode for init
    typedef union packed {
        logic [LEN_W-1:0] byte_len;
        init_arg_t        init_arg;
    } cmd_arg_u;

    typedef struct packed {
        cmd_op_e  op;
        cmd_arg_u arg;
    } cmd_t;

    // nbytes of 0 means a full word
    typedef struct packed {
        logic              is_pad;
        logic [1:0]        nbytes;
        logic [LANE_W-1:0] data;
    } fifo_entry_t;

    typedef struct packed {
        logic [LANE_W-1:0] data;
        logic              block_last;
    } lane_t;

endpackage

/* verilog/keccak_absorb_top.sv */
module keccak_absorb_top
    import keccak_absorb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_init,
    input  cmd_t              i_cmd,
    input  logic              i_cmd_valid,
    input  logic [LANE_W-1:0] i_din,
    input  logic              i_wen,
    input  logic              i_lane_ready,
    output logic              o_cmd_ready,
    output logic              o_din_ready,
    output lane_t             o_lane,
    output logic              o_lane_valid,
    output logic              o_done
);

    // loader to FIFO
    fifo_entry_t push_entry;
    logic        push_valid;
    logic        credit_return;
    // FIFO to padder
    fifo_entry_t head;
    logic        head_valid;
    logic        pop;
    // control
    logic        clear;
    logic        pad_done;
    hash_mode_e  mode;

    msg_loader i_msg_loader (
        .clk           (clk),
        .rst_init      (rst_init),
        .i_cmd         (i_cmd),
        .i_cmd_valid   (i_cmd_valid),
        .i_din         (i_din),
        .i_wen         (i_wen),
        .credit_return (credit_return),
        .pad_done      (pad_done),
        .o_cmd_ready   (o_cmd_ready),
        .o_din_ready   (o_din_ready),
        .push_entry    (push_entry),
        .push_valid    (push_valid),
        .clear         (clear),
        .mode          (mode)
    );

    word_fifo i_word_fifo (
        .clk           (clk),
        .rst_init      (rst_init),
        .clear         (clear),
        .push_entry    (push_entry),
        .push_valid    (push_valid),
        .pop           (pop),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    block_padder i_block_padder (
        .clk           (clk),
        .rst_init      (rst_init),
        .clear         (clear),
        .mode          (mode),
        .head          (head),
        .head_valid    (head_valid),
        .i_lane_ready  (i_lane_ready),
        .pop           (pop),
        .o_lane        (o_lane),
        .o_lane_valid  (o_lane_valid),
        .pad_done      (pad_done),
        .o_done        (o_done)
    );

endmodule

/* verilog/msg_loader.sv */
module msg_loader
    import keccak_absorb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_init,
    input  cmd_t              i_cmd,
    input  logic              i_cmd_valid,
    input  logic [LANE_W-1:0] i_din,
    input  logic              i_wen,
    input  logic              credit_return,
    input  logic              pad_done,
    output logic              o_cmd_ready,
    output logic              o_din_ready,
    output fifo_entry_t       push_entry,
    output logic              push_valid,
    output logic              clear,
    output hash_mode_e        mode
);

    typedef enum logic [2:0] {
        L_IDLE, L_INIT, L_ABSORB, L_FLUSH, L_PAD_PUSH, L_PAD_WAIT
    } ld_state_e;

    ld_state_e           state_q;
    logic [LEN_W-1:0]    rem_q;
    logic [CREDIT_W-1:0] credit_q;
    hash_mode_e          mode_q;
    logic                push_valid_q;
    fifo_entry_t         push_entry_q;
    logic                cmd_xfer;
    logic                word_xfer;
    logic                last_word;
    logic                pad_issue;
    logic                issue;

    assign o_cmd_ready = (state_q == L_IDLE);
    assign cmd_xfer    = i_cmd_valid & o_cmd_ready;
    assign o_din_ready = (state_q == L_ABSORB) && (credit_q != '0);
    assign word_xfer   = o_din_ready & i_wen;
    assign last_word   = (rem_q <= LEN_W'(WORD_BYTES));
    // pad token goes out right at acceptance when a credit is free
    assign pad_issue   = (credit_q != '0) &&
                         ((cmd_xfer && i_cmd.op == CMD_PAD) || state_q == L_PAD_PUSH);
    assign issue       = word_xfer | pad_issue;
    assign clear       = (state_q == L_INIT);
    assign mode        = mode_q;
    assign push_valid  = push_valid_q;
    assign push_entry  = push_entry_q;

    ////////////////////
    // command FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst_init) begin
            state_q <= L_IDLE;
            rem_q   <= '0;
            mode_q  <= SHA3_256;
        end else begin
            case (state_q)
                L_IDLE: begin
                    if (cmd_xfer) begin
                        case (i_cmd.op)
                            CMD_INIT: begin
                                mode_q  <= i_cmd.arg.init_arg.mode;
                                state_q <= L_INIT;
                            end
                            CMD_ABSORB: begin
                                rem_q <= i_cmd.arg.byte_len;
                                // empty absorb is a no-op
                                if (i_cmd.arg.byte_len != '0) state_q <= L_ABSORB;
                            end
                            CMD_PAD: state_q <= pad_issue ? L_PAD_WAIT : L_PAD_PUSH;
                            default: state_q <= L_IDLE;
                        endcase
                    end
                end
                L_INIT: state_q <= L_IDLE;
                L_ABSORB: begin
                    if (word_xfer) begin
                        rem_q <= last_word ? '0 : rem_q - LEN_W'(WORD_BYTES);
                        if (last_word) state_q <= L_FLUSH;
                    end
                end
                L_FLUSH: state_q <= L_IDLE;
                L_PAD_PUSH: if (pad_issue) state_q <= L_PAD_WAIT;
                L_PAD_WAIT: if (pad_done) state_q <= L_IDLE;
                default: state_q <= L_IDLE;
            endcase
        end
    end

    // one credit per FIFO slot
    always_ff @(posedge clk) begin
        if (rst_init || clear) begin
            credit_q <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            credit_q <= credit_q + CREDIT_W'(credit_return) - CREDIT_W'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            push_valid_q <= 1'b0;
        end else begin
            push_valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            push_entry_q.is_pad <= pad_issue;
            push_entry_q.nbytes <= last_word ? rem_q[1:0] : 2'd0;
            push_entry_q.data   <= pad_issue ? '0 : i_din;
        end
    end

endmodule

/* verilog/word_fifo.sv */
module word_fifo
    import keccak_absorb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_init,
    input  logic        clear,
    input  fifo_entry_t push_entry,
    input  logic        push_valid,
    input  logic        pop,
    output fifo_entry_t head,
    output logic        head_valid,
    output logic        credit_return
);

    fifo_entry_t      mem [FIFO_DEPTH];
    // extra msb tells full from empty
    logic [FIFO_AW:0] wr_ptr_q;
    logic [FIFO_AW:0] rd_ptr_q;
    logic             do_pop;

    ////////////////////
    // read side
    ////////////////////
    assign head_valid    = (wr_ptr_q != rd_ptr_q);
    assign head          = mem[rd_ptr_q[FIFO_AW-1:0]];
    assign do_pop        = pop & head_valid;
    // freed slot goes straight back to the loader
    assign credit_return = do_pop;

    ////////////////////
    // write side
    ////////////////////
    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr_q[FIFO_AW-1:0]] <= push_entry;
        end
    end

    // no overflow check, the loader never pushes without credit
    always_ff @(posedge clk) begin
        if (rst_init || clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule
